// File: sim/icache_trace.txt
# M word_addr data err | R start_addr words name | I index | B stall_on
# F fills expected for the command above, counting the four words prefetched after it
M 100 13572468 0
M 101 24681357 0
M 102 deadbeef 0
M 103 0badf00d 0
M 210 11112222 0
M 211 33334444 0
M 212 55556666 1
M 213 77778888 0
R 100 8 cold_miss
F 3
R 100 8 hits
F 0
I 1
F 0
R 100 8 after_inval
F 1
R 210 4 fill_error
F 5
B 1
R 340 12 back_pressure
F 4
B 0
R 500 4 conflict_a
F 2
R 100 4 conflict_b
F 2
R 500 4 conflict_again
F 2

// File: sim.f
+incdir+include
source/icache_pkg.sv
source/block_ram.sv
source/icache.sv
source/fetch_unit.sv
source/fetch_queue.sv
source/icache_top.sv
sim/icache_tb.sv

// File: sim/icache_tb.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_tb;

	localparam int addr_bits = `ICACHE_ADDR_BITS;
	localparam int line_words = `ICACHE_LINE_WORDS;
	localparam int sweep_cycles = `ICACHE_LINES;
	localparam int quiet_cycles = 32; // longer than a run of prefetch hits.

	logic clk;
	logic rst;
	logic redirect;
	logic [addr_bits-1:0] redirect_addr;
	logic inval;
	logic [`ICACHE_INDEX_BITS-1:0] inval_index;
	logic out_valid;
	logic [addr_bits-1:0] out_addr;
	logic [31:0] out_data;
	logic out_error;
	logic out_ready;
	logic m_access;
	logic [addr_bits-1:0] m_addr;
	logic [31:0] m_data;
	logic m_ack;
	logic m_error;

	integer seed = 66355;
	int cycles;
	int cycle_limit;
	int fills;
	int delay_left;
	logic access_q;
	logic [31:0] mem_data [int];
	bit mem_err [int];
	byte cmd_kind [$];
	int cmd_a [$];
	int cmd_b [$];
	string cmd_name [$];
	int cmd_fills [$];
	bit stall_on;
	int stale_left;
	logic [addr_bits-1:0] stale_next;

	icache_top u_icache_top (
		.clk(clk),
		.rst(rst),
		.redirect(redirect),
		.redirect_addr(redirect_addr),
		.inval(inval),
		.inval_index(inval_index),
		.out_valid(out_valid),
		.out_addr(out_addr),
		.out_data(out_data),
		.out_error(out_error),
		.out_ready(out_ready),
		.m_access(m_access),
		.m_addr(m_addr),
		.m_data(m_data),
		.m_ack(m_ack),
		.m_error(m_error)
	);

	always #4 clk = ~clk;

	// words not named in the trace get a pattern of the full address.
	function automatic logic [31:0] memory_word(input logic [addr_bits-1:0] a);
		if (mem_data.exists(int'(a)))
			return mem_data[int'(a)];
		return (32'(a) * 32'h9e3779b1) ^ 32'hc3a50f1e;
	endfunction

	function automatic bit memory_error(input logic [addr_bits-1:0] a);
		if (mem_err.exists(int'(a)))
			return mem_err[int'(a)];
		return 1'b0;
	endfunction

	// a fill runs from word 0, so an earlier bad word in the line spoils this one.
	function automatic bit expected_error(input logic [addr_bits-1:0] a);
		logic [addr_bits-1:0] k;
		k = a & ~addr_bits'(line_words - 1);
		while (k <= a) begin
			if (memory_error(k))
				return 1'b1;
			k = k + 1'b1;
		end
		return 1'b0;
	endfunction

	// memory side, one word per m_ack after 0 to 3 idle cycles.
	always @(posedge clk) begin
		#1;
		m_ack = 1'b0;
		m_error = 1'b0;
		if (m_access) begin
			if (delay_left == 0) begin
				m_ack = 1'b1;
				m_data = memory_word(m_addr);
				m_error = memory_error(m_addr);
				delay_left = {$random(seed)} % 4;
			end else
				delay_left--;
		end
	end

	always @(negedge clk) begin
		if (!rst && m_access && !access_q)
			fills++; // each rise of m_access starts one line fill.
		access_q = m_access;
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("run hung: no progress after %0d cycles", cycles);
			$display("TEST RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	task automatic check_word(input string name, input logic [addr_bits-1:0] exp_addr,
			input logic [31:0] exp_data, input bit with_data,
			input logic [addr_bits-1:0] act_addr, input logic [31:0] act_data);
		if (act_addr !== exp_addr || (with_data && act_data !== exp_data)) begin
			$display("Error %s: expected addr %h data %h, actual addr %h data %h",
				name, exp_addr, exp_data, act_addr, act_data);
			$display("TEST RESULT: FAIL");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual !== expected) begin
			$display("Error %s: expected %0d, actual %0d", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "count mismatch");
		end
	endtask

	task automatic take_word(input string name, input logic [addr_bits-1:0] want);
		bit err;
		err = expected_error(want);
		check_count({name, " error flag"}, int'(err), int'(out_error));
		check_word(name, want, memory_word(want), !err, out_addr, out_data);
	endtask

	// words left from the last stream come first and continue it in order.
	task automatic run_read(input logic [addr_bits-1:0] start, input int n, input string name);
		int got;
		logic [addr_bits-1:0] want;
		got = 0;
		want = start;
		@(posedge clk);
		#1;
		redirect = 1'b1;
		redirect_addr = start;
		@(posedge clk);
		#1;
		redirect = 1'b0;
		while (got < n) begin
			out_ready = stall_on ? ($random(seed) & 1) : 1'b1;
			@(negedge clk);
			if (out_valid && out_ready) begin
				if (stale_left > 0) begin
					take_word({name, " leftover"}, stale_next);
					stale_next = stale_next + 1'b1;
					stale_left--;
				end else begin
					take_word(name, want);
					want = want + 1'b1;
					got++;
				end
			end
			@(posedge clk);
			#1;
		end
		out_ready = 1'b0;
		stale_left = `ICACHE_QUEUE_DEPTH; // the queue fills up once the consumer stops.
		stale_next = start + addr_bits'(n);
	endtask

	task automatic run_inval(input int index);
		@(posedge clk);
		#1;
		inval = 1'b1;
		inval_index = index;
		@(posedge clk);
		#1;
		inval = 1'b0;
	endtask

	// with the queue full the fetch unit stops, so the bus goes quiet.
	task automatic wait_quiet();
		int quiet;
		quiet = 0;
		while (quiet < quiet_cycles) begin
			@(negedge clk);
			quiet = m_access ? 0 : quiet + 1;
		end
	endtask

	task automatic load_trace();
		int fd;
		int n;
		int a;
		int b;
		int d;
		int e;
		byte kind;
		string line;
		string nm;
		fd = $fopen("sim/icache_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file sim/icache_trace.txt");
			$display("TEST RESULT: FAIL");
			$fatal(1, "no trace");
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			n = $sscanf(line, " %c", kind);
			if (n < 1 || kind == "#")
				continue;
			case (kind)
			"M": begin
				void'($sscanf(line, "M %h %h %d", a, d, e));
				mem_data[a] = d;
				mem_err[a] = e != 0;
			end
			"R", "I", "B": begin
				b = 0;
				nm = (kind == "I") ? "invalidate" : "stall switch";
				if (kind == "R")
					void'($sscanf(line, "R %h %d %s", a, b, nm));
				else
					void'($sscanf(line, "%c %h", kind, a));
				cmd_kind.push_back(kind);
				cmd_a.push_back(a);
				cmd_b.push_back(b);
				cmd_name.push_back(nm);
				cmd_fills.push_back(-1);
			end
			"F": begin
				void'($sscanf(line, "F %d", a));
				cmd_fills[cmd_fills.size() - 1] = a;
			end
			default: $display("trace line not understood: %s", line);
			endcase
		end
		$fclose(fd);
	endtask

	initial begin
		int words;
		int start_fills;
		clk = 1'b0;
		rst = 1'b1;
		redirect = 1'b0;
		redirect_addr = '0;
		inval = 1'b0;
		inval_index = '0;
		out_ready = 1'b0;
		m_data = '0;
		m_ack = 1'b0;
		m_error = 1'b0;
		cycles = 0;
		cycle_limit = 0;
		fills = 0;
		access_q = 1'b0;
		stall_on = 1'b0;
		stale_left = 0;
		stale_next = '0;
		delay_left = {$random(seed)} % 4;
		load_trace();
		words = 0;
		foreach (cmd_kind[i])
			if (cmd_kind[i] == "R")
				words += cmd_b[i] + `ICACHE_QUEUE_DEPTH;
		cycle_limit = 64 * words + quiet_cycles * cmd_kind.size() + sweep_cycles + 16;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		foreach (cmd_kind[i]) begin
			start_fills = fills;
			case (cmd_kind[i])
			"R": begin
				run_read(cmd_a[i], cmd_b[i], cmd_name[i]);
				wait_quiet();
			end
			"I": begin
				run_inval(cmd_a[i]);
				wait_quiet();
			end
			default: stall_on = cmd_a[i] != 0;
			endcase
			if (cmd_fills[i] >= 0)
				check_count({cmd_name[i], " fills"}, cmd_fills[i], fills - start_fills);
		end
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: source/icache_top.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache_top (
	input logic clk,
	input logic rst,
	input logic redirect,
	input logic [`ICACHE_ADDR_BITS-1:0] redirect_addr,
	input logic inval,
	input logic [`ICACHE_INDEX_BITS-1:0] inval_index,
	output logic out_valid,
	output logic [`ICACHE_ADDR_BITS-1:0] out_addr,
	output logic [31:0] out_data,
	output logic out_error,
	input logic out_ready,
	output logic m_access,
	output logic [`ICACHE_ADDR_BITS-1:0] m_addr,
	input logic [31:0] m_data,
	input logic m_ack,
	input logic m_error
);

	import icache_pkg::*;

	fetch_cmd_t c_cmd;
	logic [`ICACHE_ADDR_BITS-1:0] c_addr;
	logic [`ICACHE_INDEX_BITS-1:0] c_index;
	logic c_ready;
	logic c_ack;
	logic [31:0] c_data;
	logic c_error;
	logic [$clog2(`ICACHE_QUEUE_DEPTH + 1)-1:0] queue_count;

	fetch_unit u_fetch_unit (
		.clk(clk),
		.rst(rst),
		.redirect(redirect),
		.redirect_addr(redirect_addr),
		.inval(inval),
		.inval_index(inval_index),
		.queue_count(queue_count),
		.c_cmd(c_cmd),
		.c_addr(c_addr),
		.c_index(c_index),
		.c_ready(c_ready),
		.c_ack(c_ack)
	);

	icache u_icache (
		.clk(clk),
		.rst(rst),
		.c_cmd(c_cmd),
		.c_addr(c_addr),
		.c_index(c_index),
		.c_ready(c_ready),
		.c_ack(c_ack),
		.c_data(c_data),
		.c_error(c_error),
		.m_access(m_access),
		.m_addr(m_addr),
		.m_data(m_data),
		.m_ack(m_ack),
		.m_error(m_error)
	);

	// c_addr still holds the requested word when c_ack arrives.
	fetch_queue u_fetch_queue (
		.clk(clk),
		.rst(rst),
		.push(c_ack),
		.push_addr(c_addr),
		.push_data(c_data),
		.push_error(c_error),
		.count(queue_count),
		.out_valid(out_valid),
		.out_addr(out_addr),
		.out_data(out_data),
		.out_error(out_error),
		.out_ready(out_ready)
	);

endmodule

// File: source/fetch_queue.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module fetch_queue (
	input logic clk,
	input logic rst,
	input logic push,
	input logic [`ICACHE_ADDR_BITS-1:0] push_addr,
	input logic [31:0] push_data,
	input logic push_error,
	output logic [$clog2(`ICACHE_QUEUE_DEPTH + 1)-1:0] count,
	output logic out_valid,
	output logic [`ICACHE_ADDR_BITS-1:0] out_addr,
	output logic [31:0] out_data,
	output logic out_error,
	input logic out_ready
);

	localparam int depth = `ICACHE_QUEUE_DEPTH;
	localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
	localparam int count_bits = $clog2(depth + 1);

	logic [`ICACHE_ADDR_BITS-1:0] addr_mem [depth];
	logic [31:0] data_mem [depth];
	logic error_mem [depth];
	logic [ptr_bits-1:0] wr_ptr, rd_ptr, rd_ptr_next;
	logic [count_bits-1:0] count_next;
	logic pop;

	function automatic logic [ptr_bits-1:0] inc_ptr(input logic [ptr_bits-1:0] p);
		return (p == ptr_bits'(depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign pop = out_valid && out_ready;
	assign rd_ptr_next = pop ? inc_ptr(rd_ptr) : rd_ptr;
	assign count_next = count + count_bits'(push) - count_bits'(pop);

	// count includes the word shown at the head.
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			out_valid <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= inc_ptr(wr_ptr);
			rd_ptr <= rd_ptr_next;
			count <= count_next;
			out_valid <= count_next != '0;
		end
	end

	// head registers mirror the entry at rd_ptr.
	always_ff @(posedge clk) begin
		if (push) begin
			addr_mem[wr_ptr] <= push_addr;
			data_mem[wr_ptr] <= push_data;
			error_mem[wr_ptr] <= push_error;
		end
		if (push && count == count_bits'(pop)) begin
			out_addr <= push_addr; // queue empties, new word goes straight to the head.
			out_data <= push_data;
			out_error <= push_error;
		end else begin
			out_addr <= addr_mem[rd_ptr_next];
			out_data <= data_mem[rd_ptr_next];
			out_error <= error_mem[rd_ptr_next];
		end
	end

endmodule

// File: source/fetch_unit.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module fetch_unit (
	input logic clk,
	input logic rst,
	input logic redirect,
	input logic [`ICACHE_ADDR_BITS-1:0] redirect_addr,
	input logic inval,
	input logic [`ICACHE_INDEX_BITS-1:0] inval_index,
	input logic [$clog2(`ICACHE_QUEUE_DEPTH + 1)-1:0] queue_count,
	output icache_pkg::fetch_cmd_t c_cmd,
	output logic [`ICACHE_ADDR_BITS-1:0] c_addr,
	output logic [`ICACHE_INDEX_BITS-1:0] c_index,
	input logic c_ready,
	input logic c_ack
);

	import icache_pkg::*;

	logic [`ICACHE_ADDR_BITS-1:0] next_addr;
	logic [`ICACHE_ADDR_BITS-1:0] redir_addr_q;
	logic [`ICACHE_INDEX_BITS-1:0] inval_index_q;
	logic streaming;
	logic outstanding;
	logic redir_pending;
	logic inval_pending;
	logic credit_ok;

	// words queued plus the one in flight must leave room for one more.
	assign credit_ok = (int'(queue_count) + int'(outstanding)) < `ICACHE_QUEUE_DEPTH;

	// next_addr only moves on c_ack, so c_addr names the word being returned.
	assign c_addr = next_addr;
	assign c_index = inval_index_q;

	always_comb begin
		c_cmd = cmd_none;
		if (inval_pending)
			c_cmd = cmd_inval;
		else if (streaming && !outstanding && !redir_pending && credit_ok)
			c_cmd = cmd_read;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			streaming <= 1'b0;
			outstanding <= 1'b0;
			redir_pending <= 1'b0;
			inval_pending <= 1'b0;
		end else begin
			if (c_cmd == cmd_read && c_ready)
				outstanding <= 1'b1;
			else if (c_ack) begin
				outstanding <= 1'b0;
				next_addr <= next_addr + 1'b1;
			end

			if (redir_pending && !outstanding) begin
				next_addr <= redir_addr_q;
				streaming <= 1'b1;
				redir_pending <= 1'b0;
			end
			if (redirect) begin // a later redirect replaces one still pending.
				redir_pending <= 1'b1;
				redir_addr_q <= redirect_addr;
			end

			if (c_cmd == cmd_inval && c_ready)
				inval_pending <= 1'b0;
			if (inval) begin
				inval_pending <= 1'b1;
				inval_index_q <= inval_index;
			end
		end
	end

endmodule

// File: source/icache.sv
`timescale 1ns/1ps
`include "icache_config.svh"

module icache (
	input logic clk,
	input logic rst,
	input icache_pkg::fetch_cmd_t c_cmd,
	input logic [`ICACHE_ADDR_BITS-1:0] c_addr,
	input logic [`ICACHE_INDEX_BITS-1:0] c_index,
	output logic c_ready,
	output logic c_ack,
	output logic [31:0] c_data,
	output logic c_error,
	output logic m_access,
	output logic [`ICACHE_ADDR_BITS-1:0] m_addr,
	input logic [31:0] m_data,
	input logic m_ack,
	input logic m_error
);

	import icache_pkg::*;

	localparam int offset_bits = `ICACHE_OFFSET_BITS;
	localparam int index_bits = `ICACHE_INDEX_BITS;
	localparam int tag_bits = `ICACHE_ADDR_BITS - index_bits - offset_bits;
	localparam int lines = `ICACHE_LINES;
	localparam int words = lines * `ICACHE_LINE_WORDS;

	cache_state_t state, next_state;

	logic [`ICACHE_ADDR_BITS-1:0] latched_addr;
	logic [index_bits-1:0] req_index;
	logic [index_bits-1:0] latched_index;
	logic [index_bits-1:0] sweep_index;
	logic [index_bits-1:0] valid_addr;
	logic [offset_bits-1:0] latched_offset;
	logic [offset_bits-1:0] word_offs;
	logic [tag_bits-1:0] latched_tag;
	logic [tag_bits-1:0] tag_rd;
	logic [31:0] data_rd;
	logic valid_rd;
	logic valid_wr_en;
	logic valid_wr_data;
	logic accept_read;
	logic hit;
	logic fill_word;
	logic last_word;
	logic req_word;
	logic delivered; // requested word already acked in this fill.

	assign req_index = c_addr[offset_bits +: index_bits];
	assign latched_offset = latched_addr[offset_bits-1:0];
	assign latched_index = latched_addr[offset_bits +: index_bits];
	assign latched_tag = latched_addr[offset_bits + index_bits +: tag_bits];

	assign c_ready = state == st_idle;
	assign accept_read = c_ready && c_cmd == cmd_read;
	assign hit = valid_rd && tag_rd == latched_tag;

	// fills always run from word 0 to the end of the line.
	assign m_access = state == st_fill;
	assign m_addr = {latched_addr[`ICACHE_ADDR_BITS-1:offset_bits], word_offs};

	assign fill_word = state == st_fill && m_ack && !m_error;
	assign last_word = fill_word && word_offs == {offset_bits{1'b1}};
	assign req_word = fill_word && word_offs == latched_offset;

	block_ram #(
		.data_bits(tag_bits),
		.nr_entries(lines)
	) tag_ram (
		.clk(clk),
		.read_addr(req_index),
		.read_data(tag_rd),
		.wr_en(last_word),
		.write_addr(latched_index),
		.write_data(latched_tag)
	);

	block_ram #(
		.data_bits(1),
		.nr_entries(lines)
	) valid_ram (
		.clk(clk),
		.read_addr(req_index),
		.read_data(valid_rd),
		.wr_en(valid_wr_en),
		.write_addr(valid_addr),
		.write_data(valid_wr_data)
	);

	block_ram #(
		.data_bits(32),
		.nr_entries(words)
	) data_ram (
		.clk(clk),
		.read_addr(c_addr[offset_bits + index_bits - 1:0]),
		.read_data(data_rd),
		.wr_en(fill_word),
		.write_addr({latched_index, word_offs}),
		.write_data(m_data)
	);

	// one writer of the valid bits per state.
	always_comb begin
		valid_wr_en = 1'b0;
		valid_wr_data = 1'b0;
		valid_addr = latched_index;
		case (state)
		st_sweep: begin
			valid_wr_en = 1'b1;
			valid_addr = sweep_index;
		end
		st_idle: begin
			if (c_cmd == cmd_inval) begin
				valid_wr_en = 1'b1;
				valid_addr = c_index;
			end
		end
		st_compare: valid_wr_en = !hit; // line is invalid while it is rewritten.
		st_fill: begin
			valid_wr_en = last_word;
			valid_wr_data = 1'b1;
		end
		default: valid_wr_en = 1'b0;
		endcase
	end

	always_comb begin
		next_state = state;
		case (state)
		st_sweep: begin
			if (sweep_index == index_bits'(lines - 1))
				next_state = st_idle;
		end
		st_idle: begin
			if (accept_read)
				next_state = st_compare;
		end
		st_compare: next_state = hit ? st_idle : st_fill;
		st_fill: begin
			if (m_error || last_word)
				next_state = st_idle;
		end
		default: next_state = st_sweep;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_sweep;
			sweep_index <= '0;
			word_offs <= '0;
			delivered <= 1'b0;
			c_ack <= 1'b0;
		end else begin
			state <= next_state;
			c_ack <= 1'b0;
			if (state == st_sweep)
				sweep_index <= sweep_index + 1'b1;
			if (state == st_compare) begin
				word_offs <= '0;
				delivered <= 1'b0;
				c_ack <= hit;
			end
			if (state == st_fill) begin
				if (m_error) begin
					word_offs <= '0;
					c_ack <= !delivered; // no second ack once the word went out.
				end else if (m_ack) begin
					word_offs <= word_offs + 1'b1;
					if (req_word) begin
						c_ack <= 1'b1;
						delivered <= 1'b1;
					end
				end
			end
		end
	end

	// returned word comes from the data ram on a hit, else straight off the bus.
	always_ff @(posedge clk) begin
		if (accept_read)
			latched_addr <= c_addr;
		if (state == st_compare) begin
			c_data <= data_rd;
			c_error <= 1'b0;
		end else if (state == st_fill && !delivered && (m_error || req_word)) begin
			c_data <= m_data;
			c_error <= m_error;
		end
	end

endmodule

// File: source/block_ram.sv
`timescale 1ns/1ps

module block_ram #(
	parameter int data_bits = 32,
	parameter int nr_entries = 16
) (
	input logic clk,
	input logic [$clog2(nr_entries)-1:0] read_addr,
	output logic [data_bits-1:0] read_data,
	input logic wr_en,
	input logic [$clog2(nr_entries)-1:0] write_addr,
	input logic [data_bits-1:0] write_data
);

	logic [data_bits-1:0] mem [nr_entries];

	// read returns the old contents on a same-address write.
	always_ff @(posedge clk) begin
		read_data <= mem[read_addr];
		if (wr_en)
			mem[write_addr] <= write_data;
	end

endmodule

// File: source/icache_pkg.sv
package icache_pkg;

	// cache controller state. sweep comes first so reset lands on it.
	typedef enum logic [1:0] {
		st_sweep,
		st_idle,
		st_compare,
		st_fill
	} cache_state_t;

	// operation presented to the cache on a cycle.
	typedef enum logic [1:0] {
		cmd_none,
		cmd_read,
		cmd_inval
	} fetch_cmd_t;

endpackage

// File: include/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// cache geometry in bytes.
`define ICACHE_SIZE 512
`define ICACHE_LINE_SIZE 16

// word address, so byte address bits [1:0] are not carried.
`define ICACHE_ADDR_BITS 30

// entries in the fetch queue toward the consumer.
`define ICACHE_QUEUE_DEPTH 4

`define ICACHE_LINES (`ICACHE_SIZE / `ICACHE_LINE_SIZE)
`define ICACHE_LINE_WORDS (`ICACHE_LINE_SIZE / 4)
`define ICACHE_OFFSET_BITS $clog2(`ICACHE_LINE_WORDS)
`define ICACHE_INDEX_BITS $clog2(`ICACHE_LINES)

`endif
